// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps --top-module tb_fpu_async \
    -f sources.f -o tb_fpu_async
./obj_dir/tb_fpu_async | tee sim.log
if grep -q "Simulation failed" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi
echo "Run finished without failures"
exit 0

// File: sources.f
verilog/fpu_pkg.sv
verilog/fpu_instr_queue.sv
verilog/fpu_ctrl_status.sv
verilog/fpu_exec_core.sv
verilog/fpu_async_top.sv
verification/tb_fpu_async.sv

// File: verification/tb_fpu_async.sv
// Directed testbench for fpu_async_top that checks every result against a reference stack model
module tb_fpu_async;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ISSUES = 41;     // Instructions issued over all tests
    localparam int WATCHDOG_CYCLES = NUM_ISSUES * (fpu_pkg::LAT_INIT + 4) + 100;
    localparam int IDLE_LIMIT = 64;     // Longest wait for busy to fall

    logic clk;
    logic reset;
    fpu_pkg::fpu_op_e instruction;
    logic [2:0]  stack_index;
    logic        execute;
    logic [79:0] data_in;
    logic [15:0] control_in;
    logic        control_write;
    logic        ready;
    logic        error;
    logic [79:0] data_out;
    logic [15:0] status_out;
    logic [15:0] control_out;
    logic [15:0] tag_word_out;
    logic        busy;
    logic        int_request;

    // Reference model of the register stack and flags
    logic [79:0] m_regs [8];
    logic [7:0]  m_empty;
    logic [2:0]  m_top;
    logic        m_ie;
    logic        m_sf;
    logic        m_c1;
    logic [15:0] m_ctrl;
    logic [79:0] m_out;

    logic [31:0] lfsr_state;
    logic        ready_low_seen;   // Set when an issue had to wait
    int          check_count;
    int          error_count;

    fpu_async_top u_dut (
        .clk(clk), .reset(reset), .instruction(instruction), .stack_index(stack_index),
        .execute(execute), .data_in(data_in), .control_in(control_in),
        .control_write(control_write), .ready(ready), .error(error), .data_out(data_out),
        .status_out(status_out), .control_out(control_out), .tag_word_out(tag_word_out),
        .busy(busy), .int_request(int_request)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // ============================================================
    // Stimulus helpers
    // ============================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb)
            s = s ^ 32'h8020_0003;   // Taps 32, 22, 2, 1
        return s;
    endfunction

    task automatic random_operand(output logic [79:0] v);
        for (int i = 0; i < 80; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
            v[i] = lfsr_state[0];
        end
    endtask

    task automatic issue(input fpu_pkg::fpu_op_e op, input logic [2:0] idx,
                         input logic [79:0] data);
        while (!ready) begin
            ready_low_seen = 1'b1;
            @(negedge clk);
        end
        instruction = op;
        stack_index = idx;
        data_in     = data;
        execute     = 1'b1;
        @(negedge clk);
        execute     = 1'b0;   // Single-cycle strobe
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy && cycles < IDLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("busy still high after %0d cycles at %0t", IDLE_LIMIT, $time);
            error_count++;
        end
    endtask

    // ============================================================
    // Reference model
    // ============================================================
    function automatic logic [1:0] tag_class(input logic [79:0] v);
        if (v[78:64] == 15'h7FFF) return 2'b10;          // All-ones exponent
        if (v[78:64] == 15'h0 && v[63:0] == 64'h0) return 2'b01;
        return 2'b00;
    endfunction

    function automatic logic [15:0] expected_tags();
        logic [15:0] w;
        for (int i = 0; i < 8; i++)
            w[2*i +: 2] = m_empty[i] ? 2'b11 : tag_class(m_regs[i]);
        return w;
    endfunction

    task automatic apply_model(input fpu_pkg::fpu_op_e op, input logic [2:0] idx,
                               input logic [79:0] data);
        logic [2:0]  nt;
        logic [2:0]  si;
        logic [79:0] tmp;
        nt = m_top - 3'd1;   // Slot a push lands in
        si = m_top + idx;
        case (op)
            fpu_pkg::OP_FLD: begin
                if (!m_empty[nt]) begin   // Overflow
                    m_ie = 1'b1;
                    m_sf = 1'b1;
                    m_c1 = 1'b1;
                end else begin
                    m_regs[nt]  = data;
                    m_empty[nt] = 1'b0;
                    m_top       = nt;
                end
            end
            fpu_pkg::OP_FST, fpu_pkg::OP_FSTP, fpu_pkg::OP_FCHS, fpu_pkg::OP_FABS,
            fpu_pkg::OP_FXCH: begin
                if (m_empty[m_top] || (op == fpu_pkg::OP_FXCH && m_empty[si])) begin
                    m_ie = 1'b1;   // Underflow leaves C1 alone
                    m_sf = 1'b1;
                end else if (op == fpu_pkg::OP_FXCH) begin
                    tmp          = m_regs[m_top];
                    m_regs[m_top] = m_regs[si];
                    m_regs[si]   = tmp;
                end else if (op == fpu_pkg::OP_FCHS) begin
                    m_regs[m_top][79] = ~m_regs[m_top][79];
                end else if (op == fpu_pkg::OP_FABS) begin
                    m_regs[m_top][79] = 1'b0;
                end else begin
                    m_out = m_regs[m_top];
                    if (op == fpu_pkg::OP_FSTP) begin
                        m_empty[m_top] = 1'b1;
                        m_top          = m_top + 3'd1;
                    end
                end
            end
            fpu_pkg::OP_FINIT, fpu_pkg::OP_FNINIT: begin
                m_empty = 8'hFF;
                m_top   = 3'd0;
                m_ctrl  = 16'h037F;
                m_ie    = 1'b0;
                m_sf    = 1'b0;
                m_c1    = 1'b0;
            end
            fpu_pkg::OP_FLDCW: m_ctrl = data[15:0];
            fpu_pkg::OP_FCLEX: begin
                m_ie = 1'b0;
                m_sf = 1'b0;
                m_c1 = 1'b0;
            end
            fpu_pkg::OP_FNOP: ;
            default: m_ie = 1'b1;   // Undefined opcode
        endcase
    endtask

    // ============================================================
    // Checks
    // ============================================================
    task automatic compare_value(input string name, input logic [79:0] expected,
                                 input logic [79:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s at %0t: expected %h, actual %h", name, $time,
                     expected, actual);
        end
    endtask

    task automatic check_state();
        logic        es;
        logic [15:0] st;
        es = m_ie && !m_ctrl[0];   // Unmasked invalid operation
        st = 16'h0;
        st[fpu_pkg::ST_IE_BIT] = m_ie;
        st[fpu_pkg::ST_SF_BIT] = m_sf;
        st[fpu_pkg::ST_ES_BIT] = es;
        st[fpu_pkg::ST_C1_BIT] = m_c1;
        st[fpu_pkg::ST_TOP_LSB +: 3] = m_top;
        st[fpu_pkg::ST_B_BIT]  = es;
        compare_value("data_out", m_out, data_out);
        compare_value("tag_word_out", 80'(expected_tags()), 80'(tag_word_out));
        compare_value("status_out", 80'(st), 80'(status_out));
        compare_value("control_out", 80'(m_ctrl), 80'(control_out));
        compare_value("error", 80'(es), 80'(error));
        compare_value("int_request", 80'(es), 80'(int_request));
        compare_value("ready", 80'(1'b1), 80'(ready));
        compare_value("busy", 80'(1'b0), 80'(busy));
    endtask

    task automatic run_op(input fpu_pkg::fpu_op_e op, input logic [2:0] idx,
                          input logic [79:0] data);
        apply_model(op, idx, data);
        issue(op, idx, data);
        wait_idle();
        check_state();
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic test_load_store();
        logic [79:0] vals [5];
        for (int k = 0; k < 5; k++)
            random_operand(vals[k]);
        vals[1] = 80'h0;                // Zero tag
        vals[2][78:64] = 15'h7FFF;      // Special tag
        ready_low_seen = 1'b0;
        for (int k = 0; k < 5; k++) begin
            apply_model(fpu_pkg::OP_FLD, 3'd0, vals[k]);
            issue(fpu_pkg::OP_FLD, 3'd0, vals[k]);   // Back-to-back
        end
        compare_value("busy", 80'(1'b1), 80'(busy));
        wait_idle();
        if (!ready_low_seen) begin
            $display("ready never fell while five loads were issued back-to-back");
            error_count++;
        end
        check_state();
        for (int k = 0; k < 5; k++)
            run_op(fpu_pkg::OP_FSTP, 3'd0, 80'h0);
    endtask

    task automatic test_sign_exchange();
        logic [79:0] a;
        logic [79:0] b;
        random_operand(a);
        random_operand(b);
        a[79] = 1'b1;
        b[79] = 1'b0;
        run_op(fpu_pkg::OP_FLD, 3'd0, a);
        run_op(fpu_pkg::OP_FLD, 3'd0, b);
        run_op(fpu_pkg::OP_FCHS, 3'd0, 80'h0);
        run_op(fpu_pkg::OP_FST, 3'd0, 80'h0);
        compare_value("data_out after FCHS", {1'b1, b[78:0]}, data_out);
        run_op(fpu_pkg::OP_FABS, 3'd0, 80'h0);
        run_op(fpu_pkg::OP_FST, 3'd0, 80'h0);
        compare_value("data_out after FABS", {1'b0, b[78:0]}, data_out);
        run_op(fpu_pkg::OP_FXCH, 3'd1, 80'h0);
        run_op(fpu_pkg::OP_FST, 3'd0, 80'h0);
        compare_value("data_out after FXCH", a, data_out);
        run_op(fpu_pkg::OP_FCHS, 3'd0, 80'h0);   // Negative back to positive
        run_op(fpu_pkg::OP_FST, 3'd0, 80'h0);
        compare_value("data_out after second FCHS", {1'b0, a[78:0]}, data_out);
        run_op(fpu_pkg::OP_FSTP, 3'd0, 80'h0);
        run_op(fpu_pkg::OP_FSTP, 3'd0, 80'h0);   // Stack empty again
    endtask

    task automatic test_masked_faults();
        logic [79:0] v;
        run_op(fpu_pkg::OP_FST, 3'd0, 80'h0);   // Underflow on empty stack
        for (int k = 0; k < 9; k++) begin       // Ninth load overflows
            random_operand(v);
            run_op(fpu_pkg::OP_FLD, 3'd0, v);
        end
        run_op(fpu_pkg::OP_FCLEX, 3'd0, 80'h0);
        run_op(fpu_pkg::fpu_op_e'(8'h55), 3'd0, 80'h0);
        run_op(fpu_pkg::OP_FINIT, 3'd0, 80'h0);
    endtask

    task automatic test_flush();
        logic [79:0] v;
        random_operand(v);
        apply_model(fpu_pkg::OP_FLDCW, 3'd0, 80'h037E);
        issue(fpu_pkg::OP_FLDCW, 3'd0, 80'h037E);
        issue(fpu_pkg::OP_FLD, 3'd0, v);          // Flushed behind FLDCW
        wait_idle();
        check_state();
        apply_model(fpu_pkg::OP_FST, 3'd0, 80'h0);  // Unmasked underflow
        issue(fpu_pkg::OP_FST, 3'd0, 80'h0);
        issue(fpu_pkg::OP_FLD, 3'd0, v);
        issue(fpu_pkg::OP_FLD, 3'd0, ~v);
        wait_idle();
        check_state();
        run_op(fpu_pkg::OP_FNINIT, 3'd0, 80'h0);   // Recovers past the error flush
    endtask

    task automatic test_control_write();
        control_in    = 16'h0B7F;
        control_write = 1'b1;
        @(negedge clk);
        control_write = 1'b0;
        @(negedge clk);
        m_ctrl = 16'h0B7F;
        check_state();
    endtask

    initial begin
        reset         = 1'b1;
        instruction   = fpu_pkg::OP_FNOP;
        stack_index   = 3'd0;
        execute       = 1'b0;
        data_in       = 80'h0;
        control_in    = 16'h0;
        control_write = 1'b0;
        lfsr_state    = 32'd78303;
        check_count   = 0;
        error_count   = 0;
        m_empty = 8'hFF;
        m_top   = 3'd0;
        m_ie    = 1'b0;
        m_sf    = 1'b0;
        m_c1    = 1'b0;
        m_ctrl  = 16'h037F;
        m_out   = 80'h0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        check_state();   // After reset
        test_load_store();
        test_sign_exchange();
        test_masked_faults();
        test_flush();
        test_control_write();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: verilog/fpu_async_top.sv
// FPU front end top level: issue queue, dispatcher, flush control and the BUSY output
module fpu_async_top (
    input  logic                            clk,
    input  logic                            reset,
    input  fpu_pkg::fpu_op_e                instruction,
    input  logic [fpu_pkg::STACK_IDX_W-1:0] stack_index,
    input  logic                            execute,
    input  logic [fpu_pkg::DATA_W-1:0]      data_in,
    input  logic [fpu_pkg::WORD_W-1:0]      control_in,
    input  logic                            control_write,
    output logic                            ready,
    output logic                            error,
    output logic [fpu_pkg::DATA_W-1:0]      data_out,
    output logic [fpu_pkg::WORD_W-1:0]      status_out,
    output logic [fpu_pkg::WORD_W-1:0]      control_out,
    output logic [fpu_pkg::WORD_W-1:0]      tag_word_out,
    output logic                            busy,
    output logic                            int_request
);

    logic queue_full;
    logic queue_empty;
    logic [fpu_pkg::COUNT_W-1:0] queue_count;
    fpu_pkg::fpu_op_e                head_op;
    logic [fpu_pkg::STACK_IDX_W-1:0] head_idx;
    logic [fpu_pkg::DATA_W-1:0]      head_data;

    logic enqueue;
    logic exec_start;
    logic flush;
    logic core_ready;
    logic done_flush_op;
    logic [fpu_pkg::STACK_IDX_W-1:0] top;
    logic exc_strobe;
    logic exc_invalid;
    logic exc_stack_fault;
    logic exc_c1;
    logic clear_exc;
    logic ctrl_init;
    logic ctrl_load;
    logic [fpu_pkg::WORD_W-1:0] ctrl_load_word;

    fpu_pkg::disp_state_e state;
    logic int_q;            // int_request one cycle ago
    logic head_nowait;      // Head is a non-waiting control op
    logic queue_active;

    assign enqueue = execute && !queue_full;    // Dropped while full

    fpu_instr_queue u_queue (
        .clk(clk), .reset(reset),
        .enqueue(enqueue), .opcode_in(instruction),
        .stack_index_in(stack_index), .data_in(data_in),
        .dequeue(exec_start), .flush(flush),
        .full(queue_full), .empty(queue_empty), .count(queue_count),
        .opcode_out(head_op), .stack_index_out(head_idx), .data_out(head_data)
    );

    fpu_exec_core u_core (
        .clk(clk), .reset(reset),
        .exec_start(exec_start), .opcode(head_op),
        .stack_index(head_idx), .operand(head_data),
        .core_ready(core_ready), .data_out(data_out),
        .tag_word_out(tag_word_out), .top(top),
        .exc_strobe(exc_strobe), .exc_invalid(exc_invalid),
        .exc_stack_fault(exc_stack_fault), .exc_c1(exc_c1),
        .clear_exc(clear_exc), .ctrl_init(ctrl_init),
        .ctrl_load(ctrl_load), .ctrl_load_word(ctrl_load_word),
        .done_flush_op(done_flush_op)
    );

    fpu_ctrl_status u_ctrl (
        .clk(clk), .reset(reset),
        .control_in(control_in), .control_write(control_write),
        .ctrl_load(ctrl_load), .ctrl_load_word(ctrl_load_word),
        .ctrl_init(ctrl_init), .exc_strobe(exc_strobe),
        .exc_invalid(exc_invalid), .exc_stack_fault(exc_stack_fault),
        .exc_c1(exc_c1), .clear_exc(clear_exc), .top(top),
        .control_out(control_out), .status_out(status_out),
        .error(error), .int_request(int_request)
    );

    // ============================================================
    // Flush and dispatch
    // ============================================================
    // FNINIT and FCLEX survive the error flush so software can recover
    assign head_nowait  = (head_op == fpu_pkg::OP_FNINIT) || (head_op == fpu_pkg::OP_FCLEX);
    assign queue_active = (queue_count != '0);

    assign flush = (state == fpu_pkg::DISP_BUSY && core_ready && done_flush_op)
                 || (int_request && !int_q)                         // Rising edge
                 || (int_request && queue_active && !head_nowait);

    assign exec_start = (state == fpu_pkg::DISP_IDLE) && core_ready
                     && !queue_empty && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fpu_pkg::DISP_IDLE;
            int_q <= 1'b0;
        end else begin
            int_q <= int_request;
            case (state)
                fpu_pkg::DISP_IDLE: if (exec_start) state <= fpu_pkg::DISP_BUSY;
                fpu_pkg::DISP_BUSY: if (core_ready) state <= fpu_pkg::DISP_IDLE;
                default:            state <= fpu_pkg::DISP_IDLE;
            endcase
        end
    end

    assign ready = !queue_full;
    assign busy  = !queue_empty || (state == fpu_pkg::DISP_BUSY);   // 8087 BUSY, active high

endmodule

// File: verilog/fpu_ctrl_status.sv
// Control word, sticky exception flags and status word assembly with interrupt request
module fpu_ctrl_status (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [fpu_pkg::WORD_W-1:0]      control_in,
    input  logic                            control_write,
    input  logic                            ctrl_load,
    input  logic [fpu_pkg::WORD_W-1:0]      ctrl_load_word,
    input  logic                            ctrl_init,
    input  logic                            exc_strobe,
    input  logic                            exc_invalid,
    input  logic                            exc_stack_fault,
    input  logic                            exc_c1,
    input  logic                            clear_exc,
    input  logic [fpu_pkg::STACK_IDX_W-1:0] top,
    output logic [fpu_pkg::WORD_W-1:0]      control_out,
    output logic [fpu_pkg::WORD_W-1:0]      status_out,
    output logic                            error,
    output logic                            int_request
);

    logic flag_ie;
    logic flag_sf;
    logic flag_c1;
    logic err_summary;

    // ============================================================
    // Control word
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset || ctrl_init)
            control_out <= fpu_pkg::CTRL_RESET_WORD;
        else if (ctrl_load)                  // FLDCW from the queue
            control_out <= ctrl_load_word;
        else if (control_write)              // Direct CPU write
            control_out <= control_in;
    end

    // Sticky flags, clear wins over a same-cycle strobe
    always_ff @(posedge clk) begin
        if (reset || clear_exc) begin
            flag_ie <= 1'b0;
            flag_sf <= 1'b0;
            flag_c1 <= 1'b0;
        end else if (exc_strobe) begin
            flag_ie <= flag_ie | exc_invalid;
            flag_sf <= flag_sf | exc_stack_fault;
            flag_c1 <= flag_c1 | exc_c1;
        end
    end

    // Only invalid operation is tracked, so ES is IE unmasked
    assign err_summary = flag_ie && !control_out[fpu_pkg::CTRL_IM_BIT];
    assign error       = err_summary;
    assign int_request = err_summary;

    // ============================================================
    // Status word
    // ============================================================
    always_comb begin
        status_out = '0;
        status_out[fpu_pkg::ST_IE_BIT] = flag_ie;
        status_out[fpu_pkg::ST_SF_BIT] = flag_sf;
        status_out[fpu_pkg::ST_ES_BIT] = err_summary;
        status_out[fpu_pkg::ST_C1_BIT] = flag_c1;
        status_out[fpu_pkg::ST_TOP_LSB +: fpu_pkg::STACK_IDX_W] = top;
        status_out[fpu_pkg::ST_B_BIT]  = err_summary;   // B copies ES
    end

endmodule

// File: verilog/fpu_exec_core.sv
// Execution core with the eight-register stack, TOP, tags and fixed-latency opcodes
module fpu_exec_core (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            exec_start,
    input  fpu_pkg::fpu_op_e                opcode,
    input  logic [fpu_pkg::STACK_IDX_W-1:0] stack_index,
    input  logic [fpu_pkg::DATA_W-1:0]      operand,
    output logic                            core_ready,
    output logic [fpu_pkg::DATA_W-1:0]      data_out,
    output logic [fpu_pkg::WORD_W-1:0]      tag_word_out,
    output logic [fpu_pkg::STACK_IDX_W-1:0] top,
    output logic                            exc_strobe,
    output logic                            exc_invalid,
    output logic                            exc_stack_fault,
    output logic                            exc_c1,
    output logic                            clear_exc,
    output logic                            ctrl_init,
    output logic                            ctrl_load,
    output logic [fpu_pkg::WORD_W-1:0]      ctrl_load_word,
    output logic                            done_flush_op
);

    logic [fpu_pkg::DATA_W-1:0] regs [8];   // Physical registers
    logic [7:0] empty;                      // Per physical register

    // Latched operation
    fpu_pkg::fpu_op_e                op_q;
    logic [fpu_pkg::STACK_IDX_W-1:0] idx_q;
    logic [fpu_pkg::DATA_W-1:0]      operand_q;

    logic       active;
    logic [2:0] lat_cnt;
    logic       finishing;
    logic [fpu_pkg::STACK_IDX_W-1:0] sti;      // Physical ST(i)
    logic [fpu_pkg::STACK_IDX_W-1:0] new_top;  // TOP after a push
    logic fault_over;
    logic fault_under;
    logic fault_undef;
    logic fault;

    function automatic logic [2:0] latency_of(input fpu_pkg::fpu_op_e op);
        case (op)
            fpu_pkg::OP_FLD, fpu_pkg::OP_FST,
            fpu_pkg::OP_FSTP, fpu_pkg::OP_FXCH: return 3'(fpu_pkg::LAT_STACK);
            fpu_pkg::OP_FCHS, fpu_pkg::OP_FABS: return 3'(fpu_pkg::LAT_SIGN);
            fpu_pkg::OP_FINIT, fpu_pkg::OP_FNINIT: return 3'(fpu_pkg::LAT_INIT);
            default: return 3'(fpu_pkg::LAT_MISC);
        endcase
    endfunction

    // Tag class from register contents
    function automatic logic [1:0] classify(input logic [fpu_pkg::DATA_W-1:0] v);
        if (v[78:64] == '1) return fpu_pkg::TAG_SPECIAL;
        if (v[78:0] == '0)  return fpu_pkg::TAG_ZERO;
        return fpu_pkg::TAG_VALID;
    endfunction

    always_comb begin
        for (int i = 0; i < 8; i++)
            tag_word_out[2*i +: 2] = empty[i] ? fpu_pkg::TAG_EMPTY : classify(regs[i]);
    end

    assign core_ready = !active;
    assign finishing  = active && (lat_cnt == 3'd1);
    assign sti        = top + idx_q;
    assign new_top    = top - 1'b1;

    // ============================================================
    // Stack fault decode
    // ============================================================
    always_comb begin
        fault_over  = 1'b0;
        fault_under = 1'b0;
        fault_undef = 1'b0;
        case (op_q)
            fpu_pkg::OP_FLD:  fault_over  = !empty[new_top];   // Push onto a full slot
            fpu_pkg::OP_FST, fpu_pkg::OP_FSTP,
            fpu_pkg::OP_FCHS, fpu_pkg::OP_FABS: fault_under = empty[top];
            fpu_pkg::OP_FXCH: fault_under = empty[top] || empty[sti];
            fpu_pkg::OP_FNOP, fpu_pkg::OP_FCLEX, fpu_pkg::OP_FINIT,
            fpu_pkg::OP_FLDCW, fpu_pkg::OP_FNINIT: ;
            default:          fault_undef = 1'b1;
        endcase
        fault = fault_over || fault_under || fault_undef;
    end

    // Payload and register file
    always_ff @(posedge clk) begin
        if (exec_start) begin
            op_q      <= opcode;
            idx_q     <= stack_index;
            operand_q <= operand;
        end
        if (finishing && !fault) begin
            case (op_q)
                fpu_pkg::OP_FLD:   regs[new_top] <= operand_q;
                fpu_pkg::OP_FXCH: begin
                    regs[top] <= regs[sti];
                    regs[sti] <= regs[top];
                end
                fpu_pkg::OP_FCHS:  regs[top][79] <= ~regs[top][79];
                fpu_pkg::OP_FABS:  regs[top][79] <= 1'b0;
                fpu_pkg::OP_FLDCW: ctrl_load_word <= operand_q[fpu_pkg::WORD_W-1:0];
                default: ;
            endcase
        end
    end

    // ============================================================
    // Sequencing, TOP, tags and completion pulses
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            active          <= 1'b0;
            lat_cnt         <= '0;
            top             <= '0;
            empty           <= '1;
            data_out        <= '0;
            exc_strobe      <= 1'b0;
            exc_invalid     <= 1'b0;
            exc_stack_fault <= 1'b0;
            exc_c1          <= 1'b0;
            clear_exc       <= 1'b0;
            ctrl_init       <= 1'b0;
            ctrl_load       <= 1'b0;
            done_flush_op   <= 1'b0;
        end else begin
            exc_strobe    <= 1'b0;     // One-cycle pulses
            clear_exc     <= 1'b0;
            ctrl_init     <= 1'b0;
            ctrl_load     <= 1'b0;
            done_flush_op <= 1'b0;
            if (exec_start) begin
                active  <= 1'b1;
                lat_cnt <= latency_of(opcode);
            end else if (active) begin
                lat_cnt <= lat_cnt - 1'b1;
                if (finishing) begin
                    active          <= 1'b0;
                    exc_strobe      <= 1'b1;
                    exc_invalid     <= fault;
                    exc_stack_fault <= fault_over || fault_under;
                    exc_c1          <= fault_over;    // C1 set on overflow only
                    if (!fault) begin
                        case (op_q)
                            fpu_pkg::OP_FLD: begin
                                top            <= new_top;
                                empty[new_top] <= 1'b0;
                            end
                            fpu_pkg::OP_FST:  data_out <= regs[top];
                            fpu_pkg::OP_FSTP: begin
                                data_out   <= regs[top];
                                empty[top] <= 1'b1;
                                top        <= top + 1'b1;
                            end
                            fpu_pkg::OP_FINIT, fpu_pkg::OP_FNINIT: begin
                                empty         <= '1;
                                top           <= '0;
                                ctrl_init     <= 1'b1;
                                clear_exc     <= 1'b1;
                                done_flush_op <= 1'b1;
                            end
                            fpu_pkg::OP_FLDCW: begin
                                ctrl_load     <= 1'b1;
                                done_flush_op <= 1'b1;
                            end
                            fpu_pkg::OP_FCLEX: clear_exc <= 1'b1;
                            default: ;
                        endcase
                    end
                end
            end
        end
    end

endmodule

// File: verilog/fpu_instr_queue.sv
// Three-entry instruction FIFO between CPU issue and the execution core, flushable
module fpu_instr_queue (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                enqueue,
    input  fpu_pkg::fpu_op_e                    opcode_in,
    input  logic [fpu_pkg::STACK_IDX_W-1:0]     stack_index_in,
    input  logic [fpu_pkg::DATA_W-1:0]          data_in,
    input  logic                                dequeue,
    input  logic                                flush,
    output logic                                full,
    output logic                                empty,
    output logic [fpu_pkg::COUNT_W-1:0]         count,
    output fpu_pkg::fpu_op_e                    opcode_out,
    output logic [fpu_pkg::STACK_IDX_W-1:0]     stack_index_out,
    output logic [fpu_pkg::DATA_W-1:0]          data_out
);

    // Entry storage
    fpu_pkg::fpu_op_e                   op_mem  [fpu_pkg::QUEUE_DEPTH];
    logic [fpu_pkg::STACK_IDX_W-1:0]    idx_mem [fpu_pkg::QUEUE_DEPTH];
    logic [fpu_pkg::DATA_W-1:0]         dat_mem [fpu_pkg::QUEUE_DEPTH];

    logic [fpu_pkg::COUNT_W-1:0] wr_ptr;
    logic [fpu_pkg::COUNT_W-1:0] rd_ptr;
    logic do_wr;
    logic do_rd;

    // Pointer wraps at depth, not at a power of two
    function automatic logic [fpu_pkg::COUNT_W-1:0] next_ptr(
        input logic [fpu_pkg::COUNT_W-1:0] p
    );
        if (p == fpu_pkg::COUNT_W'(fpu_pkg::QUEUE_DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    assign full  = (count == fpu_pkg::COUNT_W'(fpu_pkg::QUEUE_DEPTH));
    assign empty = (count == '0);
    assign do_wr = enqueue && !full;
    assign do_rd = dequeue && !empty;

    // Head shown combinationally
    assign opcode_out      = op_mem[rd_ptr];
    assign stack_index_out = idx_mem[rd_ptr];
    assign data_out        = dat_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            op_mem[wr_ptr]  <= opcode_in;
            idx_mem[wr_ptr] <= stack_index_in;
            dat_mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin     // Flush beats a same-cycle enqueue
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= next_ptr(wr_ptr);
            if (do_rd) rd_ptr <= next_ptr(rd_ptr);
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

endmodule

// File: verilog/fpu_pkg.sv
// Shared opcodes, field widths, latencies and status layout for the FPU front end
package fpu_pkg;

    // ============================================================
    // Field widths
    // ============================================================
    localparam int OPCODE_W    = 8;
    localparam int STACK_IDX_W = 3;
    localparam int DATA_W      = 80;   // Extended precision
    localparam int WORD_W      = 16;   // Control, status, tag words

    localparam int QUEUE_DEPTH = 3;
    localparam int COUNT_W     = 2;    // Holds 0..QUEUE_DEPTH

    // Execution cycles per opcode class
    localparam int LAT_STACK = 2;      // Load, store, store-pop, exchange
    localparam int LAT_SIGN  = 3;      // Change sign, absolute value
    localparam int LAT_INIT  = 4;      // Both initialise forms
    localparam int LAT_MISC  = 1;      // Everything else

    // ============================================================
    // Control and status words
    // ============================================================
    localparam logic [WORD_W-1:0] CTRL_RESET_WORD = 16'h037F;
    localparam int CTRL_IM_BIT = 0;    // Invalid-operation mask

    localparam int ST_IE_BIT  = 0;     // Invalid operation
    localparam int ST_SF_BIT  = 6;     // Stack fault
    localparam int ST_ES_BIT  = 7;     // Error summary
    localparam int ST_C1_BIT  = 9;     // Overflow / underflow direction
    localparam int ST_TOP_LSB = 11;    // TOP at 13:11
    localparam int ST_B_BIT   = 15;    // Busy, mirrors ES

    // Tag codes
    localparam logic [1:0] TAG_VALID   = 2'b00;
    localparam logic [1:0] TAG_ZERO    = 2'b01;
    localparam logic [1:0] TAG_SPECIAL = 2'b10;
    localparam logic [1:0] TAG_EMPTY   = 2'b11;

    typedef enum logic [OPCODE_W-1:0] {
        OP_FNOP   = 8'h00,
        OP_FLD    = 8'h10,
        OP_FST    = 8'h11,
        OP_FSTP   = 8'h12,
        OP_FXCH   = 8'h20,
        OP_FCHS   = 8'h30,
        OP_FABS   = 8'h31,
        OP_FCLEX  = 8'hE2,
        OP_FINIT  = 8'hF0,
        OP_FLDCW  = 8'hF1,
        OP_FNINIT = 8'hF6
    } fpu_op_e;

    typedef enum logic {DISP_IDLE, DISP_BUSY} disp_state_e;

endpackage
